//--- project.f
+incdir+verilog
verilog/bpPkg.sv
verilog/branchTargetBuffer.sv
verilog/branchUnit.sv
verilog/fetchAddressUnit.sv
verilog/branchPredictor.sv
bench/branchPredictorChecker.sv
bench/branchPredictorTb.sv

//--- bench/branchPredictorTb.sv
`timescale 1ns/1ps
`default_nettype none

module branchPredictorTb;

    // Cycle budget of each test
    localparam int resetCycles = 10;
    localparam int idleCycles = 20;
    localparam int missCycles = 10 * 3;
    localparam int hitCycles = 3 * 11 * 2;
    localparam int jumpCycles = 4 * 3 * 2;
    localparam int predCycles = 4 * 4;
    localparam int irqCycles = 10 + 80 + 2;
    localparam int totalCycles = resetCycles + idleCycles + missCycles + hitCycles
        + jumpCycles + predCycles + irqCycles;
    localparam int timeoutLimit = 4 * totalCycles;

    // Jump source used to move fetch to a chosen address
    localparam bpPkg::addr_t steerPc = 16'hF00F;
    // Taken pattern, MSB first, walks every hit branch row from a miss
    localparam logic [10:0] hitPattern = 11'b10110001011;

    logic clk;
    logic reset;
    logic irq;
    logic exBranch;
    logic exJump;
    logic exTaken;
    bpPkg::addr_t exPc;
    bpPkg::addr_t exTarget;
    logic exPredHit;
    bpPkg::predState_t exPredState;
    bpPkg::addr_t exPredTarget;
    wire bpPkg::addr_t fetchPc;
    wire predHit;
    wire bpPkg::predState_t predState;
    wire bpPkg::addr_t predTarget;
    wire flushPipe;

    int seed = 32693;
    int errorCount;
    int cycleCount = 0;
    int testNum = 0;
    int testsFailed = 0;
    int lastErrors = 0;
    bpPkg::addr_t addr;
    bpPkg::addr_t target;
    logic [1:0] kind;

    branchPredictor branchPredictor_i
    (
        .clk(clk), .reset(reset), .irq(irq),
        .exBranch(exBranch), .exJump(exJump), .exTaken(exTaken),
        .exPc(exPc), .exTarget(exTarget),
        .exPredHit(exPredHit), .exPredState(exPredState), .exPredTarget(exPredTarget),
        .fetchPc(fetchPc), .predHit(predHit), .predState(predState),
        .predTarget(predTarget), .flushPipe(flushPipe)
    );

    branchPredictorChecker predictorChecker_i
    (
        .clk(clk), .reset(reset), .irq(irq),
        .exBranch(exBranch), .exJump(exJump), .exTaken(exTaken),
        .exPc(exPc), .exTarget(exTarget),
        .exPredHit(exPredHit), .exPredState(exPredState), .exPredTarget(exPredTarget),
        .fetchPc(fetchPc), .predHit(predHit), .predState(predState),
        .predTarget(predTarget), .flushPipe(flushPipe),
        .errorCount(errorCount)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > timeoutLimit)
        begin
            $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // 12 addresses over 4 buffer entries, tags 1 to 3
    function automatic bpPkg::addr_t poolAddr(input int unsigned r);
        int unsigned k;
        k = r % 12;
        return bpPkg::addr_t'((k / 4 + 1) * 16 + k % 4);
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic clearInputs();
        irq = 1'b0;
        exBranch = 1'b0;
        exJump = 1'b0;
        exTaken = 1'b0;
        exPredHit = 1'b0;
    endtask

    // Unpredicted jump, fetch shows pc one cycle later
    task automatic steerTo(input bpPkg::addr_t pc);
        exJump = 1'b1;
        exPc = steerPc;
        exTarget = pc;
        nextCycle();
        clearInputs();
    endtask

    // Resolve the instruction at fetchPc with the prediction fetch got for it
    task automatic resolveHere(input logic isBranch, input logic isJump,
        input logic taken, input bpPkg::addr_t resolvedTarget);
        exBranch = isBranch;
        exJump = isJump;
        exTaken = taken;
        exPc = fetchPc;
        exTarget = resolvedTarget;
        exPredHit = predHit;
        exPredState = predState;
        exPredTarget = predTarget;
        nextCycle();
        clearInputs();
    endtask

    task automatic finishTest(input string name);
        int newErrors;
        testNum++;
        newErrors = errorCount - lastErrors;
        lastErrors = errorCount;
        if (newErrors == 0)
        begin
            $display("Test %0d %s: ok", testNum, name);
        end
        else
        begin
            $display("Test %0d %s: %0d errors", testNum, name, newErrors);
            testsFailed++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        reset = 1'b1;
        clearInputs();
        exPc = '0;
        exTarget = '0;
        exPredState = bpPkg::strongNotTaken;
        exPredTarget = '0;
        repeat (resetCycles) @(posedge clk);
        #5;
        reset = 1'b0;

        repeat (idleCycles) nextCycle();
        finishTest("idle after reset");

        // Write on a miss, then look the address up again
        for (int i = 0; i < 10; i++)
        begin
            addr = poolAddr($random(seed));
            kind = $random(seed) & 1;
            steerTo(addr);
            resolveHere(kind[0], !kind[0], $random(seed) & 1, poolAddr($random(seed)));
            steerTo(addr);
        end
        finishTest("buffer misses and aliasing");

        // Fresh entries 8 to 10 walked through every state row
        for (int i = 0; i < 3; i++)
        begin
            target = poolAddr($random(seed));
            for (int b = 10; b >= 0; b--)
            begin
                steerTo(16'h0A08 + i);
                resolveHere(1'b1, 1'b0, hitPattern[b], target);
            end
        end
        finishTest("hit branch state rows");

        // Miss, matching hit, then mismatching hit on entries 11 to 14
        for (int i = 0; i < 4; i++)
        begin
            target = poolAddr($random(seed));
            repeat (2)
            begin
                steerTo(16'h0B0B + i);
                resolveHere(1'b0, 1'b1, 1'b1, target);
            end
            steerTo(16'h0B0B + i);
            resolveHere(1'b0, 1'b1, 1'b1, target ^ 16'h0800);
        end
        finishTest("jump target match");

        // Trained weak taken entries redirect fetch on their own
        for (int i = 0; i < 4; i++)
        begin
            steerTo(16'h0B0B + i);
            repeat (3) nextCycle();
        end
        finishTest("predicted taken redirect");

        // Interrupt, then return from interrupt
        repeat (3) nextCycle();
        irq = 1'b1;
        nextCycle();
        irq = 1'b0;
        repeat (3) nextCycle();
        exBranch = 1'b1;
        exJump = 1'b1;
        nextCycle();
        clearInputs();
        repeat (2) nextCycle();
        // Random mix, kind 3 is a return from interrupt
        repeat (80)
        begin
            irq = (($random(seed) & 7) == 0);
            kind = $random(seed) & 3;
            target = ($random(seed) & 1) ? predTarget : poolAddr($random(seed));
            resolveHere(kind[1], kind[0], $random(seed) & 1, target);
        end
        repeat (2) nextCycle();
        finishTest("interrupts and random mix");

        $display("Summary: %0d tests, %0d failed, %0d errors",
            testNum, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/branchPredictorChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module branchPredictorChecker
(
    input wire clk,
    input wire reset,
    input wire irq,
    input wire exBranch,
    input wire exJump,
    input wire exTaken,
    input wire bpPkg::addr_t exPc,
    input wire bpPkg::addr_t exTarget,
    input wire exPredHit,
    input wire bpPkg::predState_t exPredState,
    input wire bpPkg::addr_t exPredTarget,
    input wire bpPkg::addr_t fetchPc,
    input wire predHit,
    input wire bpPkg::predState_t predState,
    input wire bpPkg::addr_t predTarget,
    input wire flushPipe,
    output int errorCount
);

    localparam int numEntries = 2 ** `BP_INDEX_W;

    // Hit branch rows as {flush, next state}, 3 bits per row
    // Row number is {taken, old state}
    localparam logic [23:0] hitRows = {
        3'b010, 3'b010, 3'b110, 3'b101,
        3'b100, 3'b111, 3'b000, 3'b000
    };

    // Buffer model, full address kept so the tag test is a plain compare
    logic modelValid [numEntries];
    bpPkg::addr_t modelPc [numEntries];
    bpPkg::addr_t modelTarget [numEntries];
    bpPkg::predState_t modelState [numEntries];

    // Fetch side model
    bpPkg::addr_t modelFetchPc;
    bpPkg::addr_t modelReturnPc;
    bit modelReady;

    task automatic compareValue(input string name, input logic [15:0] got,
        input logic [15:0] expected);
        if (got !== expected)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t",
                name, got, expected, $time);
            errorCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Resolution rules for the instruction in execute
    //////////////////////////////////////////////////////////////////////

    task automatic decodeResolution(output logic we, output bpPkg::predState_t ws,
        output logic flush, output bpPkg::npcSel_t sel);
        logic [2:0] row;
        we = 1'b0;
        ws = bpPkg::strongNotTaken;
        flush = 1'b0;
        // Rows without a correction leave the target selected
        sel = bpPkg::npcTarget;
        row = hitRows[3 * {exTaken, exPredState} +: 3];
        if (exBranch && exJump)
        begin
            flush = 1'b1;
            sel = bpPkg::npcReturn;
        end
        else if (exJump)
        begin
            we = 1'b1;
            ws = bpPkg::weakTaken;
            flush = !exPredHit || (exPredTarget != exTarget);
        end
        else if (exBranch)
        begin
            we = 1'b1;
            if (!exTaken)
            begin
                sel = bpPkg::npcSequential;
            end
            if (exPredHit)
            begin
                flush = row[2];
                ws = bpPkg::predState_t'(row[1:0]);
            end
            else if (exTaken)
            begin
                // Fetch fell through, so a taken miss corrects
                flush = 1'b1;
                ws = bpPkg::weakTaken;
            end
        end
        // Interrupt flushes whatever the row says
        flush = flush || irq;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare at the falling edge, then step the model
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        logic [`BP_INDEX_W-1:0] idx;
        logic modelHit;
        logic wrEn;
        logic flush;
        bpPkg::predState_t wrState;
        bpPkg::npcSel_t sel;
        bpPkg::addr_t nextPc;
        idx = modelFetchPc[`BP_INDEX_W-1:0];
        modelHit = modelReady && modelValid[idx] && (modelPc[idx] == modelFetchPc);
        decodeResolution(wrEn, wrState, flush, sel);
        if (modelReady)
        begin
            compareValue("fetchPc", fetchPc, modelFetchPc);
            compareValue("predHit", predHit, modelHit);
            // State and target only mean something on a hit
            if (modelHit)
            begin
                compareValue("predState", predState, modelState[idx]);
                compareValue("predTarget", predTarget, modelTarget[idx]);
            end
            compareValue("flushPipe", flushPipe, flush);
        end
        else
        begin
            errorCount = 0;
        end
        if (reset)
        begin
            modelFetchPc = '0;
            modelReturnPc = '0;
            for (int i = 0; i < numEntries; i++)
            begin
                modelValid[i] = 1'b0;
            end
            modelReady = 1'b1;
        end
        else if (modelReady)
        begin
            // Priority: correction, predicted taken, sequential
            if (flush && sel == bpPkg::npcReturn)
                nextPc = modelReturnPc;
            else if (flush && sel == bpPkg::npcSequential)
                nextPc = exPc + 16'd1;
            else if (flush)
                nextPc = exTarget;
            else if (modelHit && modelState[idx][1])
                nextPc = modelTarget[idx];
            else
                nextPc = modelFetchPc + 16'd1;
            if (irq)
            begin
                modelReturnPc = nextPc;
                modelFetchPc = `BP_IRQ_VECTOR;
            end
            else
            begin
                modelFetchPc = nextPc;
            end
            // Write lands after the lookup above
            if (wrEn)
            begin
                modelValid[exPc[`BP_INDEX_W-1:0]] = 1'b1;
                modelPc[exPc[`BP_INDEX_W-1:0]] = exPc;
                modelTarget[exPc[`BP_INDEX_W-1:0]] = exTarget;
                modelState[exPc[`BP_INDEX_W-1:0]] = wrState;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/branchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

module branchPredictor
(
    input wire clk,
    input wire reset,

    // Interrupt request level
    input wire irq,

    // Instruction resolving in execute
    input wire exBranch,
    input wire exJump,
    input wire exTaken,
    input wire bpPkg::addr_t exPc,
    input wire bpPkg::addr_t exTarget,

    // Prediction carried down with it
    input wire exPredHit,
    input wire bpPkg::predState_t exPredState,
    input wire bpPkg::addr_t exPredTarget,

    // Fetch side
    output wire bpPkg::addr_t fetchPc,
    output wire predHit,
    output wire bpPkg::predState_t predState,
    output wire bpPkg::addr_t predTarget,

    // Flush of fetch and decode
    output wire flushPipe
);

    //////////////////////////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////////////////////////

    // Branch unit to buffer
    wire writeEnable;
    wire bpPkg::predState_t writeState;
    // Branch unit to fetch
    wire bpPkg::npcSel_t npcSel;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    // Lookup on fetchPc, update at exPc
    branchTargetBuffer branchTargetBuffer_i
    (
        .clk(clk),
        .reset(reset),
        .lookupPc(fetchPc),
        .hit(predHit),
        .target(predTarget),
        .state(predState),
        .writeEnable(writeEnable),
        .writePc(exPc),
        .writeTarget(exTarget),
        .writeState(writeState)
    );

    // Compares outcome with the carried prediction
    branchUnit branchUnit_i
    (
        .irq(irq),
        .branch(exBranch),
        .jump(exJump),
        .taken(exTaken),
        .predHit(exPredHit),
        .predState(exPredState),
        .predTarget(exPredTarget),
        .target(exTarget),
        .writeEnable(writeEnable),
        .writeState(writeState),
        .flushPipe(flushPipe),
        .npcSel(npcSel)
    );

    // Follows the current lookup unless corrected
    fetchAddressUnit fetchAddressUnit_i
    (
        .clk(clk),
        .reset(reset),
        .irq(irq),
        .flushPipe(flushPipe),
        .npcSel(npcSel),
        .exPc(exPc),
        .exTarget(exTarget),
        .predHit(predHit),
        .predState(predState),
        .predTarget(predTarget),
        .fetchPc(fetchPc)
    );

endmodule

`default_nettype wire

//--- verilog/fetchAddressUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module fetchAddressUnit
(
    input wire clk,
    input wire reset,
    input wire irq,

    // Correction from the branch unit
    input wire flushPipe,
    input wire bpPkg::npcSel_t npcSel,
    input wire bpPkg::addr_t exPc,
    input wire bpPkg::addr_t exTarget,

    // Lookup result for the current fetch PC
    input wire predHit,
    input wire bpPkg::predState_t predState,
    input wire bpPkg::addr_t predTarget,

    output bpPkg::addr_t fetchPc
);

    // Interrupt handler entry
    localparam bpPkg::addr_t irqVector = `BP_IRQ_VECTOR;

    // Saved fetch address for return from interrupt
    bpPkg::addr_t returnPc;
    // Next address when no interrupt is taken
    bpPkg::addr_t normalNextPc;
    bpPkg::addr_t seqPc;
    logic predTaken;

    //////////////////////////////////////////////////////////////////////
    // Next address choice
    //////////////////////////////////////////////////////////////////////

    assign seqPc = fetchPc + 1'b1;

    // Bit 1 of the state is the taken prediction
    assign predTaken = predHit && predState[1];

    always_comb
    begin
        if (flushPipe)
        begin
            // Execute overrides whatever fetch predicted
            case (npcSel)
                bpPkg::npcTarget: normalNextPc = exTarget;
                bpPkg::npcSequential: normalNextPc = exPc + 1'b1;
                bpPkg::npcReturn: normalNextPc = returnPc;
                default: normalNextPc = seqPc;
            endcase
        end
        else if (predTaken)
        begin
            normalNextPc = predTarget;
        end
        else
        begin
            normalNextPc = seqPc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch PC and return register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fetchPc <= '0;
            returnPc <= '0;
        end
        else if (irq)
        begin
            // Go to the handler, remember where fetch was heading
            fetchPc <= irqVector;
            returnPc <= normalNextPc;
        end
        else
        begin
            fetchPc <= normalNextPc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit
(
    // Interrupt request level
    input wire irq,

    // Resolved instruction in execute
    input wire branch,
    input wire jump,
    input wire taken,

    // Prediction issued with that instruction
    input wire predHit,
    input wire bpPkg::predState_t predState,
    input wire bpPkg::addr_t predTarget,
    input wire bpPkg::addr_t target,

    // Buffer update
    output logic writeEnable,
    output bpPkg::predState_t writeState,

    // Fetch correction
    output logic flushPipe,
    output bpPkg::npcSel_t npcSel
);

    // Predicted target agrees with resolved target
    logic targetMatch;
    // Flush asked for by the decoded row alone
    logic rowFlush;

    assign targetMatch = (predTarget == target);

    //////////////////////////////////////////////////////////////////////
    // Resolution table
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Idle row values
        writeEnable = 1'b0;
        writeState = bpPkg::strongNotTaken;
        rowFlush = 1'b0;
        npcSel = bpPkg::npcTarget;

        case ({branch, jump})
            2'b00:
            begin
                // No control transfer in execute
            end

            2'b11:
            begin
                // Return from interrupt, buffer untouched
                rowFlush = 1'b1;
                npcSel = bpPkg::npcReturn;
            end

            2'b01:
            begin
                // Jumps always train to weak taken
                writeEnable = 1'b1;
                writeState = bpPkg::weakTaken;
                // Only a hit with the right target avoids a flush
                rowFlush = !(predHit && targetMatch);
                npcSel = bpPkg::npcTarget;
            end

            2'b10:
            begin
                writeEnable = 1'b1;
                if (!predHit)
                begin
                    // Miss, fetch went sequential
                    if (taken)
                    begin
                        writeState = bpPkg::weakTaken;
                        rowFlush = 1'b1;
                        npcSel = bpPkg::npcTarget;
                    end
                    else
                    begin
                        writeState = bpPkg::strongNotTaken;
                        npcSel = bpPkg::npcSequential;
                    end
                end
                else if (!taken)
                begin
                    // Hit, resolved not taken
                    npcSel = bpPkg::npcSequential;
                    case (predState)
                        bpPkg::strongNotTaken:
                        begin
                            writeState = bpPkg::strongNotTaken;
                        end
                        bpPkg::weakNotTaken:
                        begin
                            writeState = bpPkg::strongNotTaken;
                        end
                        bpPkg::weakTaken:
                        begin
                            // Jumps up to strong taken, as in the table
                            writeState = bpPkg::strongTaken;
                            rowFlush = 1'b1;
                        end
                        bpPkg::strongTaken:
                        begin
                            writeState = bpPkg::strongNotTaken;
                            rowFlush = 1'b1;
                        end
                    endcase
                end
                else
                begin
                    // Hit, resolved taken
                    npcSel = bpPkg::npcTarget;
                    case (predState)
                        bpPkg::strongNotTaken:
                        begin
                            writeState = bpPkg::weakNotTaken;
                            rowFlush = 1'b1;
                        end
                        bpPkg::weakNotTaken:
                        begin
                            writeState = bpPkg::weakTaken;
                            rowFlush = 1'b1;
                        end
                        bpPkg::weakTaken:
                        begin
                            writeState = bpPkg::weakTaken;
                        end
                        bpPkg::strongTaken:
                        begin
                            // Falls back to weak taken
                            writeState = bpPkg::weakTaken;
                        end
                    endcase
                end
            end
        endcase
    end

    // Interrupt flushes fetch and decode on top of any row
    assign flushPipe = rowFlush || irq;

endmodule

`default_nettype wire

//--- verilog/branchTargetBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module branchTargetBuffer
(
    input wire clk,
    input wire reset,

    // Lookup side, driven from the fetch PC
    input wire bpPkg::addr_t lookupPc,
    output logic hit,
    output bpPkg::addr_t target,
    output bpPkg::predState_t state,

    // Update side, driven at branch resolution
    input wire writeEnable,
    input wire bpPkg::addr_t writePc,
    input wire bpPkg::addr_t writeTarget,
    input wire bpPkg::predState_t writeState
);

    //////////////////////////////////////////////////////////////////////
    // Table geometry
    //////////////////////////////////////////////////////////////////////

    localparam int numEntries = 2 ** `BP_INDEX_W;
    // Tag is everything above the index
    localparam int tagWidth = `BP_ADDR_W - `BP_INDEX_W;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // Valid bits are the only control state
    logic [numEntries-1:0] validBits;

    // Entry payload
    logic [tagWidth-1:0] tagMem [numEntries];
    bpPkg::addr_t targetMem [numEntries];
    bpPkg::predState_t stateMem [numEntries];

    // Address split for both ports
    logic [`BP_INDEX_W-1:0] lookupIdx;
    logic [tagWidth-1:0] lookupTag;
    logic [`BP_INDEX_W-1:0] writeIdx;
    logic [tagWidth-1:0] writeTag;
    logic tagMatch;

    assign lookupIdx = lookupPc[`BP_INDEX_W-1:0];
    assign lookupTag = lookupPc[`BP_ADDR_W-1:`BP_INDEX_W];
    assign writeIdx = writePc[`BP_INDEX_W-1:0];
    assign writeTag = writePc[`BP_ADDR_W-1:`BP_INDEX_W];

    //////////////////////////////////////////////////////////////////////
    // Combinational lookup
    //////////////////////////////////////////////////////////////////////

    // Tag compare on the selected entry
    assign tagMatch = (tagMem[lookupIdx] == lookupTag);

    // Hit needs a valid entry and a matching tag
    assign hit = validBits[lookupIdx] && tagMatch;

    // Miss reads back as a not-taken entry with target 0
    assign target = hit ? targetMem[lookupIdx] : '0;
    assign state = hit ? stateMem[lookupIdx] : bpPkg::strongNotTaken;

    //////////////////////////////////////////////////////////////////////
    // Registered update
    //////////////////////////////////////////////////////////////////////

    // Valid bits, cleared on reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            validBits <= '0;
        end
        else if (writeEnable)
        begin
            validBits[writeIdx] <= 1'b1;
        end
    end

    // Whole entry written at once
    // Visible to lookup from the next cycle on
    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            tagMem[writeIdx] <= writeTag;
            targetMem[writeIdx] <= writeTarget;
            stateMem[writeIdx] <= writeState;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bpPkg.sv
`default_nettype none

`include "bp_defines.svh"

package bpPkg;

    //////////////////////////////////////////////////////////////////////
    // Shared front end types
    //////////////////////////////////////////////////////////////////////

    // One instruction address
    typedef logic [`BP_ADDR_W-1:0] addr_t;

    // 2-bit saturating prediction state
    // Bit 1 set means predict taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } predState_t;

    // Source of the corrected fetch address
    // 2'b11 is not produced by the branch unit
    typedef enum logic [1:0] {
        npcTarget     = 2'b00,
        npcSequential = 2'b01,
        npcReturn     = 2'b10
    } npcSel_t;

endpackage

`default_nettype wire

//--- verilog/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Front end sizing macros

// Instruction address width in bits
`define BP_ADDR_W 16

// Branch target buffer index bits
// 4 bits gives 16 direct-mapped entries
`define BP_INDEX_W 4

// Fetch address of the interrupt handler
`define BP_IRQ_VECTOR 16'h0100

`endif
